/* flist.f */
+incdir+logic
logic/smartnic_pkg.sv
logic/axis_full_pipe.sv
logic/axil_peripheral_term.sv
logic/smartnic_322mhz_app.sv
test/smartnic_props.sv
test/tb_smartnic_322mhz_app.sv

/* logic/axil_peripheral_term.sv */
`include "smartnic_cfg.svh"

module axil_peripheral_term
    import smartnic_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,

    // Write address
    input  logic     awvalid,
    output logic     awready,
    input  axil_aw_t aw,

    // Write data
    input  logic     wvalid,
    output logic     wready,
    input  axil_w_t  w,

    // Write response
    output logic     bvalid,
    input  logic     bready,
    output logic [1:0] bresp,

    // Read address
    input  logic     arvalid,
    output logic     arready,
    input  axil_aw_t ar,

    // Read data
    output logic     rvalid,
    input  logic     rready,
    output axil_r_t  r
);

    // No register lies behind this port, so aw, w and ar payloads are
    // accepted and dropped

    // ------------------------------------------------------------------
    // Write channel
    // ------------------------------------------------------------------

    logic aw_seen;
    logic w_seen;
    logic aw_done;
    logic w_done;

    // One write in flight at a time
    assign awready = ~aw_seen & ~bvalid;
    assign wready  = ~w_seen & ~bvalid;

    // Address and data either held from earlier or taken this cycle
    assign aw_done = aw_seen | (awvalid & awready);
    assign w_done  = w_seen | (wvalid & wready);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            aw_seen <= 1'b0;
            w_seen  <= 1'b0;
            bvalid  <= 1'b0;
        end else begin
            if (bvalid) begin
                // Hold response until the manager takes it
                if (bready) begin
                    bvalid <= 1'b0;
                end
            end else if (aw_done && w_done) begin
                bvalid  <= 1'b1;
                aw_seen <= 1'b0;
                w_seen  <= 1'b0;
            end else begin
                aw_seen <= aw_done;
                w_seen  <= w_done;
            end
        end
    end

    // Every write misses
    assign bresp = `SMARTNIC_RESP_DECERR;

    // ------------------------------------------------------------------
    // Read channel
    // ------------------------------------------------------------------

    assign arready = ~rvalid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rvalid <= 1'b0;
        end else begin
            if (arvalid && arready) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // Fixed read word with a decode error
    assign r.data = `SMARTNIC_TERM_RDATA;
    assign r.resp = `SMARTNIC_RESP_DECERR;

endmodule : axil_peripheral_term

/* logic/axis_full_pipe.sv */
module axis_full_pipe #(
    parameter type PAYLOAD_T = logic [7:0]
) (
    input  logic     clk,
    input  logic     rst_n,

    // Upstream side
    input  logic     in_valid,
    output logic     in_ready,
    input  PAYLOAD_T in_data,

    // Downstream side
    output logic     out_valid,
    input  logic     out_ready,
    output PAYLOAD_T out_data
);

    // ------------------------------------------------------------------
    // Storage
    // ------------------------------------------------------------------

    // Main entry drives the output, skid entry parks one beat on a stall
    logic     main_valid;
    logic     skid_valid;
    PAYLOAD_T main_data;
    PAYLOAD_T skid_data;

    logic     in_fire;
    logic     main_free;
    logic     load_main;
    logic     load_skid;

    // Skid only fills while main is held, so a full skid means both full.
    // Ready comes straight from a flop.
    assign in_ready = ~skid_valid;
    assign in_fire  = in_valid & in_ready;

    // Main entry empties or hands its beat on this edge
    assign main_free = ~main_valid | out_ready;

    // Skid beat is always older than any new input
    assign load_main = main_free & (skid_valid | in_fire);
    assign load_skid = ~main_free & in_fire;

    // ------------------------------------------------------------------
    // Control
    // ------------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            main_valid <= 1'b0;
            skid_valid <= 1'b0;
        end else begin
            if (main_free) begin
                // Skid drains into main, input is blocked while skid is full
                main_valid <= skid_valid | in_fire;
                skid_valid <= 1'b0;
            end else if (in_fire) begin
                skid_valid <= 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------
    // Payload
    // ------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (load_main) begin
            main_data <= skid_valid ? skid_data : in_data;
        end
        if (load_skid) begin
            skid_data <= in_data;
        end
    end

    // Output is registered
    assign out_valid = main_valid;
    assign out_data  = main_data;

endmodule : axis_full_pipe

/* logic/smartnic_322mhz_app.sv */
`include "smartnic_cfg.svh"

module smartnic_322mhz_app
    import smartnic_pkg::*;
#(
    parameter int NUM_PORTS = `SMARTNIC_NUM_PORTS
) (
    input  logic           core_clk,
    input  logic           rst_n,

    // ------------------------------------------------------------------
    // Second processor slot ingress from the switch
    // ------------------------------------------------------------------
    input  logic [NUM_PORTS-1:0] from_switch_tvalid,
    output logic [NUM_PORTS-1:0] from_switch_tready,
    input  axis_in_beat_t        from_switch [NUM_PORTS],

    // ------------------------------------------------------------------
    // First processor slot egress to the switch
    // ------------------------------------------------------------------
    output logic [NUM_PORTS-1:0] to_switch_tvalid,
    input  logic [NUM_PORTS-1:0] to_switch_tready,
    output axis_out_beat_t       to_switch [NUM_PORTS],

    // ------------------------------------------------------------------
    // Unused processor control port
    // ------------------------------------------------------------------
    // Write address
    input  logic           axil_awvalid,
    output logic           axil_awready,
    input  axil_aw_t       axil_aw,
    // Write data
    input  logic           axil_wvalid,
    output logic           axil_wready,
    input  axil_w_t        axil_w,
    // Write response
    output logic           axil_bvalid,
    input  logic           axil_bready,
    output logic [1:0]     axil_bresp,
    // Read address
    input  logic           axil_arvalid,
    output logic           axil_arready,
    input  axil_aw_t       axil_ar,
    // Read data
    output logic           axil_rvalid,
    input  logic           axil_rready,
    output axil_r_t        axil_r
);

    // Ingress to egress beat with tdest widened, pid kept and no
    // truncation or RSS hint
    function automatic axis_out_beat_t to_egress(input axis_in_beat_t b);
        axis_out_beat_t o;
        o.tdata              = b.tdata;
        o.tkeep              = b.tkeep;
        o.tlast              = b.tlast;
        o.tid                = b.tid;
        o.tdest              = egr_tdest_t'(b.tdest);
        o.tuser.pid          = b.pid;
        o.tuser.trunc_enable = 1'b0;
        o.tuser.trunc_length = '0;
        o.tuser.rss_enable   = 1'b0;
        o.tuser.rss_entropy  = '0;
        return o;
    endfunction

    // ------------------------------------------------------------------
    // Switch loopback with one independent pipe per port
    // ------------------------------------------------------------------

    axis_out_beat_t egr_beat [NUM_PORTS];

    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_port
        assign egr_beat[i] = to_egress(from_switch[i]);

        axis_full_pipe #(
            .PAYLOAD_T (axis_out_beat_t)
        ) u_loop_pipe (
            .clk       (core_clk),
            .rst_n     (rst_n),
            .in_valid  (from_switch_tvalid[i]),
            .in_ready  (from_switch_tready[i]),
            .in_data   (egr_beat[i]),
            .out_valid (to_switch_tvalid[i]),
            .out_ready (to_switch_tready[i]),
            .out_data  (to_switch[i])
        );
    end : g_port

    // ------------------------------------------------------------------
    // Control port terminator
    // ------------------------------------------------------------------

    axil_peripheral_term u_axil_term (
        .clk     (core_clk),
        .rst_n   (rst_n),
        .awvalid (axil_awvalid),
        .awready (axil_awready),
        .aw      (axil_aw),
        .wvalid  (axil_wvalid),
        .wready  (axil_wready),
        .w       (axil_w),
        .bvalid  (axil_bvalid),
        .bready  (axil_bready),
        .bresp   (axil_bresp),
        .arvalid (axil_arvalid),
        .arready (axil_arready),
        .ar      (axil_ar),
        .rvalid  (axil_rvalid),
        .rready  (axil_rready),
        .r       (axil_r)
    );

endmodule : smartnic_322mhz_app

/* logic/smartnic_cfg.svh */
`ifndef SMARTNIC_CFG_SVH
`define SMARTNIC_CFG_SVH

// ------------------------------------------------------------------
// Stream data path
// ------------------------------------------------------------------

// Bytes per 512-bit stream beat
`define SMARTNIC_AXIS_DATA_BYTES 64

// Packet id carried alongside each beat
`define SMARTNIC_PID_WID 16

// Loopback ports between the two processor slots
`define SMARTNIC_NUM_PORTS 2

// ------------------------------------------------------------------
// AXI-Lite control port
// ------------------------------------------------------------------

`define SMARTNIC_AXIL_ADDR_WID 32
`define SMARTNIC_AXIL_DATA_WID 32

// DECERR returned on every access to the unused port
`define SMARTNIC_RESP_DECERR 2'd3

// Read word of the terminated port
`define SMARTNIC_TERM_RDATA 32'hDEADBEEF

`endif

/* logic/smartnic_pkg.sv */
`include "smartnic_cfg.svh"

package smartnic_pkg;

    // ------------------------------------------------------------------
    // Port and destination ids
    // ------------------------------------------------------------------

    // Switch port id used for ingress tid and tdest
    typedef logic [1:0] port_t;

    // Egress destination is one bit wider than a switch port
    typedef logic [2:0] egr_tdest_t;

    // ------------------------------------------------------------------
    // Egress side-band metadata
    // ------------------------------------------------------------------

    typedef struct packed {
        logic [`SMARTNIC_PID_WID-1:0] pid;
        logic                         trunc_enable;
        logic [15:0]                  trunc_length;
        logic                         rss_enable;
        logic [11:0]                  rss_entropy;
    } tuser_meta_t;

    // ------------------------------------------------------------------
    // Stream beats
    // ------------------------------------------------------------------

    // Beat from the switch carries only the pid as metadata
    typedef struct packed {
        logic [`SMARTNIC_AXIS_DATA_BYTES*8-1:0] tdata;
        logic [`SMARTNIC_AXIS_DATA_BYTES-1:0]   tkeep;
        logic                                   tlast;
        port_t                                  tid;
        port_t                                  tdest;
        logic [`SMARTNIC_PID_WID-1:0]           pid;
    } axis_in_beat_t;

    // Beat toward the switch with full metadata
    typedef struct packed {
        logic [`SMARTNIC_AXIS_DATA_BYTES*8-1:0] tdata;
        logic [`SMARTNIC_AXIS_DATA_BYTES-1:0]   tkeep;
        logic                                   tlast;
        port_t                                  tid;
        egr_tdest_t                             tdest;
        tuser_meta_t                            tuser;
    } axis_out_beat_t;

    // ------------------------------------------------------------------
    // AXI-Lite channel payloads
    // ------------------------------------------------------------------

    // Shared by the write and read address channels
    typedef struct packed {
        logic [`SMARTNIC_AXIL_ADDR_WID-1:0] addr;
        logic [2:0]                         prot;
    } axil_aw_t;

    typedef struct packed {
        logic [`SMARTNIC_AXIL_DATA_WID-1:0]   data;
        logic [`SMARTNIC_AXIL_DATA_WID/8-1:0] strb;
    } axil_w_t;

    typedef struct packed {
        logic [`SMARTNIC_AXIL_DATA_WID-1:0] data;
        logic [1:0]                         resp;
    } axil_r_t;

endpackage : smartnic_pkg

/* run_sim.sh */
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_smartnic_322mhz_app -Mdir "$BUILD_DIR" -o sim_tb -f flist.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/sim_tb" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "TB PASSED" "$LOG_FILE"; then
    echo "Result: pass"
    exit 0
fi
echo "Result: fail"
exit 1

/* test/smartnic_props.sv */
`include "smartnic_cfg.svh"

module smartnic_props
    import smartnic_pkg::*;
#(
    parameter int NUM_PORTS = `SMARTNIC_NUM_PORTS
) (
    input logic                 core_clk,
    input logic                 rst_n,
    input logic [NUM_PORTS-1:0] to_switch_tvalid,
    input logic [NUM_PORTS-1:0] to_switch_tready,
    input axis_out_beat_t       to_switch [NUM_PORTS],
    input logic                 axil_bvalid,
    input logic                 axil_bready,
    input logic [1:0]           axil_bresp,
    input logic                 axil_rvalid,
    input logic                 axil_rready,
    input axil_r_t              axil_r
);
    timeunit 1ns;
    timeprecision 1ps;

    // Failed assertion count
    int fail_count = 0;

    // Stalled egress beat keeps valid and payload
    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_port
        a_egress_hold: assert property (@(posedge core_clk) disable iff (!rst_n)
            to_switch_tvalid[i] && !to_switch_tready[i]
                |=> to_switch_tvalid[i] && $stable(to_switch[i]))
            else begin
                fail_count++;
                $error("egress beat on port %0d changed before ready", i);
            end
    end : g_port

    a_bresp_hold: assert property (@(posedge core_clk) disable iff (!rst_n)
        axil_bvalid && !axil_bready |=> axil_bvalid && $stable(axil_bresp))
        else begin
            fail_count++;
            $error("write response dropped before bready");
        end

    a_rdata_hold: assert property (@(posedge core_clk) disable iff (!rst_n)
        axil_rvalid && !axil_rready |=> axil_rvalid && $stable(axil_r))
        else begin
            fail_count++;
            $error("read response dropped before rready");
        end

    a_idle_in_reset: assert property (@(posedge core_clk)
        !rst_n |-> (to_switch_tvalid == '0) && !axil_bvalid && !axil_rvalid)
        else begin
            fail_count++;
            $error("valid output high during reset");
        end

endmodule : smartnic_props

/* test/tb_smartnic_322mhz_app.sv */
`include "smartnic_cfg.svh"

module tb_smartnic_322mhz_app
    import smartnic_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_PORTS   = `SMARTNIC_NUM_PORTS;
    localparam int CW          = $bits(axis_out_beat_t);
    localparam int BEATS       = 300;
    localparam int BURST       = 50;
    localparam int LONG_LIMIT  = 20000;
    localparam int SHORT_LIMIT = 200;
    localparam int DATA_WORDS  = `SMARTNIC_AXIS_DATA_BYTES / 4;
    localparam int KEEP_WORDS  = `SMARTNIC_AXIS_DATA_BYTES / 32;
    localparam logic [31:0] SEED = 32'h53069dd6;

    logic                 core_clk;
    logic                 rst_n;
    logic [NUM_PORTS-1:0] from_switch_tvalid;
    logic [NUM_PORTS-1:0] from_switch_tready;
    axis_in_beat_t        from_switch [NUM_PORTS];
    logic [NUM_PORTS-1:0] to_switch_tvalid;
    logic [NUM_PORTS-1:0] to_switch_tready;
    axis_out_beat_t       to_switch [NUM_PORTS];
    logic                 axil_awvalid;
    logic                 axil_awready;
    logic                 axil_wvalid;
    logic                 axil_wready;
    logic                 axil_bvalid;
    logic                 axil_bready;
    logic                 axil_arvalid;
    logic                 axil_arready;
    logic                 axil_rvalid;
    logic                 axil_rready;
    logic [1:0]           axil_bresp;
    axil_aw_t             axil_aw;
    axil_aw_t             axil_ar;
    axil_w_t              axil_w;
    axil_r_t              axil_r;

    // Reference model state
    logic [31:0]          lfsr;
    axis_out_beat_t       model_q [NUM_PORTS][$];
    int                   in_cnt [NUM_PORTS];
    logic [NUM_PORTS-1:0] in_fired;

    smartnic_322mhz_app uut (.*);

    bind smartnic_322mhz_app smartnic_props #(.NUM_PORTS(NUM_PORTS)) u_props (
        .core_clk         (core_clk),
        .rst_n            (rst_n),
        .to_switch_tvalid (to_switch_tvalid),
        .to_switch_tready (to_switch_tready),
        .to_switch        (to_switch),
        .axil_bvalid      (axil_bvalid),
        .axil_bready      (axil_bready),
        .axil_bresp       (axil_bresp),
        .axil_rvalid      (axil_rvalid),
        .axil_rready      (axil_rready),
        .axil_r           (axil_r)
    );

    initial begin
        core_clk = 1'b0;
        forever begin
            #5 core_clk = ~core_clk;
        end
    end

    // ------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic axis_in_beat_t random_beat();
        axis_in_beat_t b;
        for (int k = 0; k < DATA_WORDS; k++) begin
            b.tdata[k*32 +: 32] = rand_bits(32);
        end
        for (int k = 0; k < KEEP_WORDS; k++) begin
            b.tkeep[k*32 +: 32] = rand_bits(32);
        end
        b.tlast = 1'(rand_bits(1));
        b.tid   = port_t'(rand_bits(2));
        b.tdest = port_t'(rand_bits(2));
        b.pid   = 16'(rand_bits(16));
        return b;
    endfunction

    // Fields copied, tdest gets a zero on top, trunc and RSS all zero
    function automatic axis_out_beat_t expected_egress(input axis_in_beat_t b);
        return {b.tdata, b.tkeep, b.tlast, b.tid, 1'b0, b.tdest, b.pid, 30'd0};
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_equal(input logic [CW-1:0] got, input logic [CW-1:0] exp,
                               input string what);
        if (got !== exp) begin
            report_failure($sformatf("CHECK FAILED at %0t: %s, got %0h, expected %0h",
                                     $time, what, got, exp));
        end
    endtask

    task automatic count_wait_cycle(inout int cyc, input int limit, input string what);
        cyc++;
        if (cyc > limit) begin
            report_failure($sformatf("Timed out at %0t waiting for %s", $time, what));
        end
    endtask

    // ------------------------------------------------------------------
    // Stream stimulus and model
    // ------------------------------------------------------------------

    // Offered beat stays put until taken
    task automatic drive_ports(input int target, input bit random_mode);
        logic offer;
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (!from_switch_tvalid[p] || in_fired[p]) begin
                offer = (in_cnt[p] < target);
                if (offer && random_mode) begin
                    offer = (rand_bits(1) == 32'd1);
                end
                from_switch_tvalid[p] = offer;
                if (offer) begin
                    from_switch[p] = random_beat();
                end
            end
            if (random_mode) begin
                to_switch_tready[p] = (rand_bits(2) != 32'd0);
            end else begin
                to_switch_tready[p] = 1'b1;
            end
        end
    endtask

    // All beats sent and matched on every port
    function automatic bit ports_done(input int target);
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (in_cnt[p] != target || model_q[p].size() != 0) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic run_traffic(input int target, input bit random_mode, input string what);
        int cyc;
        cyc = 0;
        while (!ports_done(target)) begin
            @(negedge core_clk);
            drive_ports(target, random_mode);
            count_wait_cycle(cyc, LONG_LIMIT, what);
        end
        check_equal(CW'(to_switch_tvalid), '0, "egress idle once every beat is out");
    endtask

    // Egress is checked before the same edge's ingress is pushed
    always @(posedge core_clk) begin
        if (rst_n) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (to_switch_tvalid[p] && to_switch_tready[p]) begin
                    if (model_q[p].size() == 0) begin
                        report_failure($sformatf("Egress beat on port %0d at %0t with none sent",
                                                 p, $time));
                    end
                    check_equal(CW'(to_switch[p]), CW'(model_q[p].pop_front()),
                                $sformatf("egress beat on port %0d", p));
                end
                in_fired[p] = from_switch_tvalid[p] && from_switch_tready[p];
                if (in_fired[p]) begin
                    model_q[p].push_back(expected_egress(from_switch[p]));
                    in_cnt[p]++;
                end
            end
        end
    end

    // ------------------------------------------------------------------
    // AXI-Lite transactions
    // ------------------------------------------------------------------

    // Order 0 sends address first, 1 sends data first, 2 sends both together
    task automatic axil_write(input int order);
        bit aw_done;
        bit w_done;
        int cyc;
        aw_done = 1'b0;
        w_done  = 1'b0;
        cyc     = 0;
        @(negedge core_clk);
        axil_aw.addr = rand_bits(32);
        axil_aw.prot = 3'(rand_bits(3));
        axil_w.data  = rand_bits(32);
        axil_w.strb  = 4'(rand_bits(4));
        axil_awvalid = (order != 1);
        axil_wvalid  = (order != 0);
        while (!(aw_done && w_done)) begin
            @(posedge core_clk);
            aw_done = aw_done | (axil_awvalid & axil_awready);
            w_done  = w_done | (axil_wvalid & axil_wready);
            @(negedge core_clk);
            axil_awvalid = !aw_done && (order != 1 || w_done);
            axil_wvalid  = !w_done && (order != 0 || aw_done);
            count_wait_cycle(cyc, SHORT_LIMIT, "write address and data acceptance");
        end
        axil_bready = 1'b1;
        cyc = 0;
        do begin
            @(posedge core_clk);
            count_wait_cycle(cyc, SHORT_LIMIT, "write response");
        end while (!(axil_bvalid && axil_bready));
        check_equal(CW'(axil_bresp), CW'(`SMARTNIC_RESP_DECERR), "write response code");
        @(negedge core_clk);
        axil_bready = 1'b0;
        repeat (3) begin
            check_equal(CW'(axil_bvalid), '0, "no second write response");
            @(negedge core_clk);
        end
    endtask

    task automatic axil_read();
        int cyc;
        int delay;
        cyc   = 0;
        delay = rand_bits(3);
        @(negedge core_clk);
        axil_ar.addr = rand_bits(32);
        axil_ar.prot = 3'(rand_bits(3));
        axil_arvalid = 1'b1;
        do begin
            @(posedge core_clk);
            count_wait_cycle(cyc, SHORT_LIMIT, "read address acceptance");
        end while (!(axil_arvalid && axil_arready));
        @(negedge core_clk);
        axil_arvalid = 1'b0;
        // rvalid must hold while rready lags
        repeat (delay) @(negedge core_clk);
        axil_rready = 1'b1;
        cyc = 0;
        do begin
            @(posedge core_clk);
            count_wait_cycle(cyc, SHORT_LIMIT, "read data");
        end while (!(axil_rvalid && axil_rready));
        check_equal(CW'(axil_r.data), CW'(`SMARTNIC_TERM_RDATA), "read data word");
        check_equal(CW'(axil_r.resp), CW'(`SMARTNIC_RESP_DECERR), "read response code");
        @(negedge core_clk);
        axil_rready = 1'b0;
    endtask

    // ------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------

    initial begin
        int run;
        int cyc;
        lfsr               = SEED;
        rst_n              = 1'b0;
        from_switch_tvalid = '0;
        to_switch_tready   = '0;
        in_fired           = '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            from_switch[p] = '0;
            in_cnt[p]      = 0;
        end
        axil_awvalid = 1'b0;
        axil_wvalid  = 1'b0;
        axil_bready  = 1'b0;
        axil_arvalid = 1'b0;
        axil_rready  = 1'b0;
        axil_aw      = '0;
        axil_w       = '0;
        axil_ar      = '0;

        repeat (8) @(posedge core_clk);
        @(negedge core_clk);
        rst_n = 1'b1;
        @(negedge core_clk);
        check_equal(CW'({to_switch_tvalid, axil_bvalid, axil_rvalid}), '0,
                    "valid outputs idle after reset");
        check_equal(CW'({from_switch_tready, axil_awready, axil_wready, axil_arready}),
                    CW'({(NUM_PORTS+3){1'b1}}), "ready outputs high after reset");

        // Random traffic with egress back-pressure
        run_traffic(BEATS, 1'b1, "random traffic on all ports");

        // Back-to-back burst where egress must not skip a cycle once started
        run = 0;
        cyc = 0;
        while (run < BURST) begin
            @(negedge core_clk);
            drive_ports(BEATS + BURST, 1'b0);
            if (run > 0 || to_switch_tvalid != '0) begin
                check_equal(CW'(to_switch_tvalid), CW'({NUM_PORTS{1'b1}}),
                            "one egress beat per cycle in burst");
                run++;
            end
            count_wait_cycle(cyc, SHORT_LIMIT, "burst egress beats");
        end
        run_traffic(BEATS + BURST, 1'b0, "burst drain");

        for (int k = 0; k < 6; k++) begin
            axil_write(k % 3);
        end
        repeat (8) begin
            axil_read();
        end

        if (uut.u_props.fail_count == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            report_failure($sformatf("%0d bound handshake assertions failed",
                                     uut.u_props.fail_count));
        end
    end

endmodule : tb_smartnic_322mhz_app
